/* rtl/rv32_pkg.sv */
package rv32_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_br    = 7'b1100011,
        op_store = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // encoded as the branch funct3 field.
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } br_op_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } st_size_t;

    typedef struct packed {
        opcode_t   opcode;
        alu_op_t   alu_op;
        br_op_t    br_op;
        st_size_t  st_size;
        logic      use_imm;
        logic      reg_we;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        ctrl_t ctrl;
        word_t imm;
        word_t rs1_val;
        word_t rs2_val;
    } id_ex_t;

    // result is the ALU value, or the byte address for a store.
    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t store_data;
    } ex_mem_t;

endpackage

/* rtl/stage_if.sv */
`timescale 1ns/100ps

// hand-off between two pipeline stages.
// hold freezes the producer's register, kill loads it with a bubble.
interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    payload_t payload;
    logic     hold;
    logic     kill;

    modport producer (
        output valid,
        output payload,
        input  hold,
        input  kill
    );

    modport consumer (
        input  valid,
        input  payload,
        output hold,
        output kill
    );

endinterface

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output logic      inst_read,
    output word_t     inst_addr,
    input  word_t     inst_rdata,
    input  logic      inst_resp,
    input  logic      redirect_valid,
    input  word_t     redirect_pc,
    stage_if.producer out_s
);

    word_t  pc;
    logic   valid_q;
    if_id_t if_id_q;

    assign inst_addr     = pc;
    assign out_s.valid   = valid_q;
    assign out_s.payload = if_id_q;

    // the read strobe comes up one cycle after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_read <= 1'b0;
        end else begin
            inst_read <= 1'b1;
        end
    end

    // a redirect wins even while the pipe is held.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (!out_s.hold && inst_read) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (out_s.kill) begin
            valid_q <= 1'b0;
        end else if (!out_s.hold) begin
            valid_q <= inst_read && inst_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_s.hold) begin
            if_id_q.pc    <= pc;
            if_id_q.instr <= inst_rdata;
        end
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    stage_if.consumer in_s,
    stage_if.producer out_s,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_val,
    input  word_t     rs2_val
);

    word_t      instr;
    logic [2:0] funct3;
    logic       funct7_b5;
    alu_op_t    alu_f3;
    ctrl_t      ctrl;
    word_t      imm;
    logic       legal;
    logic       valid_q;
    id_ex_t     id_ex_q;

    assign instr     = in_s.payload.instr;
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // stall and flush pass straight through to fetch.
    assign in_s.hold = out_s.hold;
    assign in_s.kill = out_s.kill;

    assign rs1_addr      = ctrl.rs1;
    assign rs2_addr      = ctrl.rs2;
    assign out_s.valid   = valid_q;
    assign out_s.payload = id_ex_q;

    // sub only exists in register form, sra shares funct7 with srai.
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (instr[6:0] == op_reg && funct7_b5) ? alu_sub : alu_add;
            3'b001:  alu_f3 = alu_sll;
            3'b010:  alu_f3 = alu_slt;
            3'b011:  alu_f3 = alu_sltu;
            3'b100:  alu_f3 = alu_xor;
            3'b101:  alu_f3 = funct7_b5 ? alu_sra : alu_srl;
            3'b110:  alu_f3 = alu_or;
            default: alu_f3 = alu_and;
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.opcode  = opcode_t'(instr[6:0]);
        ctrl.rd      = instr[11:7];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.br_op   = br_op_t'(funct3);
        ctrl.st_size = st_size_t'(funct3);
        ctrl.reg_we  = (instr[11:7] != '0);
        ctrl.alu_op  = alu_add;
        ctrl.use_imm = 1'b1;
        imm          = {{20{instr[31]}}, instr[31:20]};
        legal        = 1'b1;
        case (ctrl.opcode)
            op_imm: begin
                ctrl.rs2    = '0;
                ctrl.alu_op = alu_f3;
            end
            op_reg: begin
                ctrl.alu_op  = alu_f3;
                ctrl.use_imm = 1'b0;
            end
            op_lui: begin
                // x0 plus the upper immediate.
                ctrl.rs1 = '0;
                ctrl.rs2 = '0;
                imm      = {instr[31:12], 12'h000};
            end
            op_br: begin
                imm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                legal = (funct3[2:1] != 2'b01);
            end
            op_store: begin
                imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                legal = (funct3 <= 3'b010);
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (out_s.kill) begin
            valid_q <= 1'b0;
        end else if (!out_s.hold) begin
            valid_q <= in_s.valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_s.hold) begin
            id_ex_q.pc      <= in_s.payload.pc;
            id_ex_q.ctrl    <= ctrl;
            id_ex_q.imm     <= imm;
            id_ex_q.rs1_val <= rs1_val;
            id_ex_q.rs2_val <= rs2_val;
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/100ps

module reg_file
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output word_t     rs1_val,
    output word_t     rs2_val
);

    // x0 has no storage.
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // a same-cycle write is seen by the reader.
    assign rs1_val = (rs1_addr == '0) ? '0 :
                     (wb_we && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 :
                     (wb_we && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    stage_if.consumer in_s,
    stage_if.producer out_s,
    input  logic      wb_we,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    id_ex_t  ex;
    logic    mem_fwd_ok;
    logic    wb_fwd_ok;
    word_t   op_a;
    word_t   rs2_fwd;
    word_t   op_b;
    word_t   alu_res;
    logic    taken;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    logic    valid_q;

    assign ex = in_s.payload;

    assign mem_fwd_ok = valid_q && ex_mem_q.ctrl.reg_we && ex_mem_q.ctrl.rd != '0;
    assign wb_fwd_ok  = wb_we && wb_rd != '0;

    // the instruction in MEM is younger than the one in writeback.
    always_comb begin
        if (mem_fwd_ok && ex_mem_q.ctrl.rd == ex.ctrl.rs1) begin
            op_a = ex_mem_q.result;
        end else if (wb_fwd_ok && wb_rd == ex.ctrl.rs1) begin
            op_a = wb_data;
        end else begin
            op_a = ex.rs1_val;
        end
        if (mem_fwd_ok && ex_mem_q.ctrl.rd == ex.ctrl.rs2) begin
            rs2_fwd = ex_mem_q.result;
        end else if (wb_fwd_ok && wb_rd == ex.ctrl.rs2) begin
            rs2_fwd = wb_data;
        end else begin
            rs2_fwd = ex.rs2_val;
        end
    end

    assign op_b = ex.ctrl.use_imm ? ex.imm : rs2_fwd;

    always_comb begin
        case (ex.ctrl.alu_op)
            alu_sub:  alu_res = op_a - op_b;
            alu_and:  alu_res = op_a & op_b;
            alu_or:   alu_res = op_a | op_b;
            alu_xor:  alu_res = op_a ^ op_b;
            alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_sll:  alu_res = op_a << op_b[4:0];
            alu_srl:  alu_res = op_a >> op_b[4:0];
            alu_sra:  alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            default:  alu_res = op_a + op_b;
        endcase
    end

    // branches always compare the two registers.
    always_comb begin
        case (ex.ctrl.br_op)
            bne:     taken = (op_a != rs2_fwd);
            blt:     taken = ($signed(op_a) < $signed(rs2_fwd));
            bge:     taken = ($signed(op_a) >= $signed(rs2_fwd));
            bltu:    taken = (op_a < rs2_fwd);
            bgeu:    taken = (op_a >= rs2_fwd);
            default: taken = (op_a == rs2_fwd);
        endcase
    end

    assign redirect_valid = in_s.valid && ex.ctrl.opcode == op_br && taken;
    assign redirect_pc    = ex.pc + ex.imm;

    // a taken branch flushes the two younger entries.
    assign in_s.kill = redirect_valid;
    assign in_s.hold = out_s.hold;

    always_comb begin
        ex_mem_d             = '0;
        ex_mem_d.ctrl        = ex.ctrl;
        ex_mem_d.ctrl.reg_we = ex.ctrl.reg_we &&
                               ex.ctrl.opcode != op_br && ex.ctrl.opcode != op_store;
        ex_mem_d.result      = alu_res;
        ex_mem_d.store_data  = rs2_fwd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (out_s.kill) begin
            valid_q <= 1'b0;
        end else if (!out_s.hold) begin
            valid_q <= in_s.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_s.hold) begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign out_s.valid   = valid_q;
    assign out_s.payload = ex_mem_q;

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    stage_if.consumer  in_s,
    output logic       data_write,
    output logic [3:0] data_mbe,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  logic       data_resp,
    output logic       mem_busy,
    output logic       wb_we,
    output reg_addr_t  wb_rd,
    output word_t      wb_data
);

    ex_mem_t    mem;
    logic [1:0] offset;
    logic       is_store;
    logic       st_done;

    assign mem      = in_s.payload;
    assign offset   = mem.result[1:0];
    assign is_store = in_s.valid && mem.ctrl.opcode == op_store;

    // the store already in MEM is older than any branch.
    assign in_s.kill = 1'b0;

    // a store answered during a fetch stall must not be issued twice.
    always_ff @(posedge clk) begin
        if (rst) begin
            st_done <= 1'b0;
        end else if (!in_s.hold) begin
            st_done <= 1'b0;
        end else if (data_write && data_resp) begin
            st_done <= 1'b1;
        end
    end

    assign data_write = is_store && !st_done;
    assign mem_busy   = data_write && !data_resp;
    assign data_addr  = {mem.result[31:2], 2'b00};

    always_comb begin
        case (mem.ctrl.st_size)
            sb: begin
                data_wdata = mem.store_data << {offset, 3'b000};
                data_mbe   = 4'b0001 << offset;
            end
            sh: begin
                data_wdata = mem.store_data << {offset[1], 4'b0000};
                data_mbe   = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                data_wdata = mem.store_data;
                data_mbe   = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else if (!in_s.hold) begin
            wb_we <= in_s.valid && mem.ctrl.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!in_s.hold) begin
            wb_rd   <= mem.ctrl.rd;
            wb_data <= mem.result;
        end
    end

endmodule

/* rtl/rv32_core.sv */
`timescale 1ns/100ps

module rv32_core
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output logic       inst_read,
    output word_t      inst_addr,
    input  logic       inst_resp,
    input  word_t      inst_rdata,
    output logic       data_write,
    output logic [3:0] data_mbe,
    output word_t      data_addr,
    output word_t      data_wdata,
    input  logic       data_resp
);

    logic      stall;
    logic      mem_busy;
    logic      redirect_valid;
    word_t     redirect_pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_val;
    word_t     rs2_val;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    stage_if #(.payload_t(if_id_t))  f2d ();
    stage_if #(.payload_t(id_ex_t))  d2e ();
    stage_if #(.payload_t(ex_mem_t)) e2m ();

    // global stall enters at the back and travels upstream.
    assign stall    = !inst_resp || mem_busy;
    assign e2m.hold = stall;

    fetch_stage u_fetch (
        .clk            (clk),
        .rst            (rst),
        .inst_read      (inst_read),
        .inst_addr      (inst_addr),
        .inst_rdata     (inst_rdata),
        .inst_resp      (inst_resp),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .out_s          (f2d.producer)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_s     (f2d.consumer),
        .out_s    (d2e.producer),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst            (rst),
        .in_s           (d2e.consumer),
        .out_s          (e2m.producer),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst        (rst),
        .in_s       (e2m.consumer),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp),
        .mem_busy   (mem_busy),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

/* testbench/rv32_ref.svh */
`ifndef RV32_REF_SVH
`define RV32_REF_SVH

// one store as seen on the data port, data keeps only the enabled lanes.
typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [3:0] mbe;
} store_t;

// expected stores in program order.
store_t exp_q [$];

function automatic word_t lane_mask(input logic [3:0] mbe);
    return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
endfunction

// alt is bit 30 of the instruction where it selects sub or sra.
function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'd0, $signed(a) < $signed(b)};
        3'b011:  return {31'd0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// runs the program until it branches to itself.
// returns the number of stores queued, or -1 if the step limit runs out.
function automatic int rv32_ref(input int max_steps);
    word_t      x [0:31];
    word_t      pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    word_t      ea;
    logic [2:0] f3;
    logic [4:0] rd;
    store_t     st;
    pc = '0;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    exp_q.delete();
    for (int step = 0; step < max_steps; step++) begin
        ins   = imem_word(pc);
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        case (ins[6:0])
            7'b0110111: x[rd] = {ins[31:12], 12'h000};
            7'b0010011: x[rd] = alu_result(f3, ins[30] && f3 == 3'b101, a, imm_i);
            7'b0110011: x[rd] = alu_result(f3, ins[30], a, b);
            7'b0100011: begin
                ea      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                st.addr = {ea[31:2], 2'b00};
                case (f3)
                    3'b000:  st.mbe = 4'b0001 << ea[1:0];
                    3'b001:  st.mbe = 4'b0011 << ea[1:0];
                    default: st.mbe = 4'b1111;
                endcase
                st.data = (b << {ea[1:0], 3'b000}) & lane_mask(st.mbe);
                exp_q.push_back(st);
            end
            7'b1100011: begin
                if (branch_taken(f3, a, b)) begin
                    if (imm_b == '0) begin
                        return exp_q.size();
                    end
                    // the step below adds the four back.
                    pc = pc + imm_b - 32'd4;
                end
            end
            default: ;
        endcase
        x[0] = '0;
        pc   = pc + 32'd4;
    end
    return -1;
endfunction

`endif

/* testbench/tb_rv32_core.sv */
`timescale 1ns/100ps

module tb_rv32_core
    import rv32_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       inst_read;
    word_t      inst_addr;
    logic       inst_resp;
    word_t      inst_rdata;
    logic       data_write;
    logic [3:0] data_mbe;
    word_t      data_addr;
    word_t      data_wdata;
    logic       data_resp;

    word_t      prog [0:255];
    int         prog_len   = 0;
    int         slot       = 32'h100;
    int         n_exp      = 0;
    int         seen       = 0;
    int         mismatches = 0;
    int         failures   = 0;
    logic       waiting    = 1'b0;
    word_t      held_addr;
    word_t      held_wdata;
    logic [3:0] held_mbe;

    // locations past the program read as addi x0, x0, 0.
    function automatic word_t imem_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len) begin
            return prog[idx];
        end
        return 32'h0000_0013;
    endfunction

    `include "rv32_ref.svh"

    function automatic word_t r_op(input logic [2:0] f3, input logic alt, input int rd,
                                   input int rs1, input int rs2);
        return {1'b0, alt, 5'b00000, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic word_t i_op(input logic [2:0] f3, input int rd, input int rs1,
                                   input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op_imm};
    endfunction

    function automatic word_t u_op(input int rd, input int imm);
        return {imm[19:0], rd[4:0], op_lui};
    endfunction

    function automatic word_t s_op(input logic [2:0] f3, input int rs2, input int rs1,
                                   input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], op_store};
    endfunction

    function automatic word_t b_op(input logic [2:0] f3, input int rs1, input int rs2,
                                   input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_br};
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic store_word(input int rs);
        emit(s_op(3'b010, rs, 0, slot));
        slot += 4;
    endtask

    // branch over two poison stores, x26 counts the cases reached.
    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2);
        emit(b_op(f3, rs1, rs2, 12));
        emit(s_op(3'b010, 1, 0, 32'h3f0));
        emit(s_op(3'b010, 2, 0, 32'h3f4));
        emit(i_op(3'b000, 26, 26, 1));
        store_word(26);
    endtask

    task automatic load_program();
        // x1 positive, x2 negative.
        emit(u_op(1, 32'h12345));
        emit(i_op(3'b000, 1, 1, 32'h678));
        emit(i_op(3'b000, 2, 0, -3));
        emit(r_op(3'b000, 1'b0, 3, 1, 2));
        emit(r_op(3'b000, 1'b1, 4, 1, 2));
        emit(r_op(3'b111, 1'b0, 5, 1, 2));
        emit(r_op(3'b110, 1'b0, 6, 1, 2));
        emit(r_op(3'b100, 1'b0, 7, 1, 2));
        emit(r_op(3'b010, 1'b0, 8, 2, 1));
        emit(r_op(3'b011, 1'b0, 9, 2, 1));
        emit(i_op(3'b000, 10, 0, 4));
        emit(r_op(3'b001, 1'b0, 11, 1, 10));
        emit(r_op(3'b101, 1'b0, 12, 2, 10));
        emit(r_op(3'b101, 1'b1, 13, 2, 10));
        for (int r = 3; r <= 13; r++) begin
            store_word(r);
        end
        emit(i_op(3'b010, 14, 2, 5));
        emit(i_op(3'b011, 15, 1, -1));
        emit(i_op(3'b100, 16, 1, 32'hf0f));
        emit(i_op(3'b110, 17, 2, 32'h0ff));
        emit(i_op(3'b111, 18, 1, 32'h7f0));
        emit(i_op(3'b001, 19, 1, 7));
        emit(i_op(3'b101, 20, 2, 9));
        emit(i_op(3'b101, 21, 2, 32'h409));
        for (int r = 14; r <= 21; r++) begin
            store_word(r);
        end
        // consumers at distance one, two and three.
        emit(i_op(3'b000, 22, 1, 1));
        store_word(22);
        emit(i_op(3'b000, 23, 22, 2));
        emit(i_op(3'b000, 0, 0, 0));
        store_word(23);
        emit(r_op(3'b000, 1'b0, 24, 23, 22));
        emit(i_op(3'b000, 0, 0, 0));
        emit(i_op(3'b000, 0, 0, 0));
        store_word(24);
        emit(i_op(3'b000, 25, 2, 0));
        branch_case(blt, 25, 1);
        branch_case(beq, 1, 1);
        branch_case(beq, 1, 2);
        branch_case(bne, 1, 2);
        branch_case(bne, 1, 1);
        branch_case(blt, 1, 2);
        branch_case(bge, 1, 2);
        branch_case(bge, 2, 1);
        branch_case(bltu, 1, 2);
        branch_case(bltu, 2, 1);
        branch_case(bgeu, 2, 1);
        branch_case(bgeu, 1, 2);
        // short backward loop, three passes.
        emit(i_op(3'b000, 27, 0, 3));
        emit(i_op(3'b000, 27, 27, -1));
        store_word(27);
        emit(b_op(bne, 27, 0, -8));
        for (int k = 0; k < 4; k++) begin
            emit(s_op(3'b000, 1, 0, 32'h200 + k));
        end
        emit(s_op(3'b001, 1, 0, 32'h210));
        emit(s_op(3'b001, 2, 0, 32'h212));
        emit(b_op(beq, 0, 0, 0));
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic accept_store();
        store_t st;
        if (exp_q.size() == 0) begin
            failures++;
            $display("unexpected store at %0t to address %h", $time, data_addr);
        end else begin
            st = exp_q.pop_front();
            check_value("data_addr", data_addr, st.addr);
            check_value("data_mbe", {28'd0, data_mbe}, {28'd0, st.mbe});
            check_value("data_wdata", data_wdata & lane_mask(st.mbe), st.data);
        end
        seen++;
    endtask

    rv32_core UUT (
        .clk        (clk),
        .rst        (rst),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_resp  (data_resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // both response strobes are low about a quarter of the time.
    initial begin
        void'($urandom(32'ha9b8));
        forever begin
            @(negedge clk);
            inst_rdata <= imem_word(inst_addr);
            if (rst) begin
                inst_resp <= 1'b1;
                data_resp <= 1'b0;
            end else begin
                inst_resp <= ($urandom % 4) != 0;
                data_resp <= ($urandom % 4) != 0;
            end
        end
    end

    // a pending store must hold address, data and enables until answered.
    always @(posedge clk) begin
        if (!rst) begin
            if (data_write) begin
                if (waiting) begin
                    check_value("data_addr", data_addr, held_addr);
                    check_value("data_wdata", data_wdata, held_wdata);
                    check_value("data_mbe", {28'd0, data_mbe}, {28'd0, held_mbe});
                end
                if (data_resp) begin
                    accept_store();
                    waiting = 1'b0;
                end else begin
                    waiting    = 1'b1;
                    held_addr  = data_addr;
                    held_wdata = data_wdata;
                    held_mbe   = data_mbe;
                end
            end else if (waiting) begin
                failures++;
                $display("data_write dropped at %0t before the store was answered", $time);
                waiting = 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        rst        = 1'b1;
        inst_resp  = 1'b1;
        inst_rdata = 32'h0000_0013;
        data_resp  = 1'b0;
        load_program();
        n_exp = rv32_ref(100000);
        if (n_exp < 0) begin
            failures++;
            $display("reference model never reached the closing self loop");
        end
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            check_value("data_write", {31'd0, data_write}, 32'd0);
            check_value("inst_read", {31'd0, inst_read}, 32'd0);
        end
        rst <= 1'b0;
        cycles = 0;
        while (seen < n_exp && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        if (seen < n_exp) begin
            failures++;
            $display("timeout after %0d cycles with %0d of %0d stores seen", cycles, seen, n_exp);
        end
        // the core spins on its last branch and must not store again.
        cycles = 0;
        while (cycles < 30) begin
            @(negedge clk);
            cycles++;
        end
        $display("stores seen %0d of %0d, mismatches %0d, other failures %0d",
                 seen, n_exp, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+testbench
rtl/rv32_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/rv32_core.sv
testbench/tb_rv32_core.sv
